// ==== logic/mc_block_ctrl.sv ====
/*
 * Block controller
 * Runs idle, fetch and mix phases, latches the block flags on a start
 * and steps the mix address through the 32 prediction words
 */
module mc_block_ctrl
	import mc_geom_pkg::*;
	import mc_stream_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   block_start,
	input  half_flags_t            flags_in,
	input  logic                   coded_in,
	input  logic                   fetch_done,
	output logic                   ready,
	output logic                   fetching,
	output half_flags_t            flags,
	output logic                   coded,
	output logic                   mix_active,
	output logic [PRED_ADDR_W-1:0] pixel_addr
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_MIX
	} state_t;

	state_t state;
	logic   start_take;
	logic   mix_last;

	assign start_take = block_start && (state == ST_IDLE);
	assign mix_last   = (state == ST_MIX) && (&pixel_addr);	// Word 31

	// --------------------
	// Phase FSM
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_take)
						state <= ST_FETCH;
				end
				ST_FETCH: begin
					if (fetch_done)
						state <= ST_MIX;
				end
				ST_MIX: begin
					if (mix_last)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Block parameters held for the whole block
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			flags <= '0;
			coded <= 1'b0;
		end else if (start_take) begin
			flags <= flags_in;
			coded <= coded_in;
		end
	end

	// Mix address, wraps back to 0 after the last word
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			pixel_addr <= '0;
		else if (state == ST_MIX)
			pixel_addr <= pixel_addr + 1'b1;
	end

	assign ready      = (state == ST_IDLE);
	assign fetching   = (state == ST_FETCH);
	assign mix_active = (state == ST_MIX);

	// --------------------
	// Checks
	a_start_in_idle: assert property (@(posedge clk) disable iff (!reset_n)
		block_start |-> (state == ST_IDLE));
	a_done_in_fetch: assert property (@(posedge clk) disable iff (!reset_n)
		fetch_done |-> (state == ST_FETCH));

endmodule

// ==== logic/mc_geom_pkg.sv ====
/*
 * Motion compensation block geometry
 * Pixel widths, lane split and reference fetch shape for one 8x8 luma block
 */
package mc_geom_pkg;

	// --------------------
	// Pixel widths
	localparam int PIX_W = 8;	// Reference and output pixel
	localparam int RES_W = 9;	// Signed residual, -256..255

	// --------------------
	// Output block shape
	localparam int LANES         = 2;	// Even and odd pixel lanes
	localparam int COLS_PER_LANE = 4;	// Words per output row
	localparam int BLOCK_ROWS    = 8;

	// --------------------
	// Reference fetch shape
	localparam int REF_ROWS      = 9;	// One extra row for vertical half-pel
	localparam int BEATS_PER_ROW = 5;	// Ten pixels, nine needed with xhalf
	localparam int REF_BEATS     = REF_ROWS * BEATS_PER_ROW;

	// Counter widths
	localparam int PRED_ADDR_W = 5;	// {row[2:0], col[1:0]}
	localparam int COL_W       = 2;
	localparam int ROW_W       = 4;

endpackage

// ==== logic/mc_half_pel_lane.sv ====
/*
 * Half-pel lane
 * Rounded x-sum, vertical sum against the previous row and the
 * 32-entry prediction buffer for one pixel lane
 */
module mc_half_pel_lane
	import mc_geom_pkg::*;
	import mc_stream_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  half_flags_t            flags,
	input  lane_pair_t             pair,
	input  logic [PRED_ADDR_W-1:0] pixel_addr,
	output logic [PIX_W-1:0]       pred
);

	// Previous row x-sums, one per column
	logic [PIX_W:0]   line_q [COLS_PER_LANE];
	// Prediction buffer, indexed {row, col}
	logic [PIX_W-1:0] pred_mem [BLOCK_ROWS * COLS_PER_LANE];

	logic [PIX_W:0]         xsum;	// a + b + 1
	logic [PIX_W+1:0]       ysum;
	logic [ROW_W-1:0]       wr_row;
	logic [PRED_ADDR_W-1:0] wr_addr;
	logic                   wr_en;

	// --------------------
	// Rounding adders
	assign xsum = {1'b0, pair.a} + {1'b0, pair.b} + 1'b1;

	always_comb begin
		if (flags.yhalf)
			ysum = {1'b0, line_q[pair.col]} + {1'b0, xsum};
		else
			ysum = {xsum, 1'b0};	// Doubled, same scale as the y-sum
	end

	// --------------------
	// Write placement
	// With yhalf a row completes the output row above it
	always_comb begin
		if (flags.yhalf) begin
			wr_row = pair.row - 1'b1;
			wr_en  = pair.valid && (pair.row != 0);
		end else begin
			wr_row = pair.row;
			wr_en  = pair.valid && (pair.row < BLOCK_ROWS);	// Row 8 unused
		end
	end

	assign wr_addr = {wr_row[2:0], pair.col};

	always_ff @(posedge clk) begin
		if (pair.valid)
			line_q[pair.col] <= xsum;
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			pred_mem[wr_addr] <= ysum[PIX_W+1:2];	// Drop the two rounding bits
	end

	assign pred = pred_mem[pixel_addr];

	// Flags may only change between blocks, never inside a run of pairs
	a_flags_stable: assert property (@(posedge clk) disable iff (!reset_n)
		pair.valid && $past(pair.valid) |-> $stable(flags));

endmodule

// ==== logic/mc_recon_drain.sv ====
/*
 * Reconstruction drain
 * Adds the residual to each lane's prediction, clips to 0..255
 * and registers the output word with its address
 */
module mc_recon_drain
	import mc_geom_pkg::*;
	import mc_stream_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        mix_active,
	input  logic                        coded,
	input  logic [PRED_ADDR_W-1:0]      pixel_addr,
	input  logic [LANES-1:0][PIX_W-1:0] preds,
	input  residual_t                   residual,
	output logic                        out_valid,
	output recon_word_t                 out_word
);

	ref_beat_t mix_data;

	// Prediction 0..255 plus residual -256..255 gives -256..510
	function automatic logic [PIX_W-1:0] mix_px(
		input logic [PIX_W-1:0]        p,
		input logic signed [RES_W-1:0] d,
		input logic                    use_d
	);
		logic signed [RES_W:0] res;
		logic signed [RES_W:0] sum;
		res = use_d ? {d[RES_W-1], d} : '0;	// Uncoded block reads as zero
		sum = $signed({2'b00, p}) + res;
		if (sum[RES_W])
			mix_px = '0;	// Negative
		else if (sum[RES_W-1])
			mix_px = '1;	// Above 255
		else
			mix_px = sum[PIX_W-1:0];
	endfunction

	assign mix_data.px0 = mix_px(preds[0], residual.d0, coded);
	assign mix_data.px1 = mix_px(preds[1], residual.d1, coded);

	// --------------------
	// Output register
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			out_valid <= 1'b0;
		else
			out_valid <= mix_active;
	end

	always_ff @(posedge clk) begin
		if (mix_active) begin
			out_word.addr <= pixel_addr;
			out_word.data <= mix_data;
		end
	end

	a_addr_step: assert property (@(posedge clk) disable iff (!reset_n)
		out_valid && $past(out_valid) |-> out_word.addr == $past(out_word.addr) + 1'b1);

endmodule

// ==== logic/mc_recon_top.sv ====
/*
 * MPEG-2 motion compensation reconstruction core
 * One 8x8 luma block: reference fetch, half-pel lanes and residual mix
 */
module mc_recon_top
	import mc_geom_pkg::*;
	import mc_stream_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   block_start,
	input  half_flags_t            flags,
	input  logic                   coded,
	output logic                   ready,
	input  logic                   ref_valid,
	input  ref_beat_t              ref_beat,
	output logic [PRED_ADDR_W-1:0] pixel_addr,
	input  residual_t              residual,
	output logic                   out_valid,
	output recon_word_t            out_word
);

	half_flags_t                 blk_flags;	// Latched for the block
	logic                        blk_coded;
	logic                        fetching;
	logic                        fetch_done;
	logic                        mix_active;
	lane_pair_t [LANES-1:0]      pairs;
	logic [LANES-1:0][PIX_W-1:0] preds;

	mc_block_ctrl u_ctrl (
		.clk        (clk),
		.reset_n    (reset_n),
		.block_start(block_start),
		.flags_in   (flags),
		.coded_in   (coded),
		.fetch_done (fetch_done),
		.ready      (ready),
		.fetching   (fetching),
		.flags      (blk_flags),
		.coded      (blk_coded),
		.mix_active (mix_active),
		.pixel_addr (pixel_addr)
	);

	mc_ref_splitter u_split (
		.clk       (clk),
		.reset_n   (reset_n),
		.fetching  (fetching),
		.flags     (blk_flags),
		.ref_valid (ref_valid),
		.ref_beat  (ref_beat),
		.pairs     (pairs),
		.fetch_done(fetch_done)
	);

	// Lane 0 holds even pixels, lane 1 odd pixels
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		mc_half_pel_lane u_lane (
			.clk       (clk),
			.reset_n   (reset_n),
			.flags     (blk_flags),
			.pair      (pairs[i]),
			.pixel_addr(pixel_addr),
			.pred      (preds[i])
		);
	end

	mc_recon_drain u_drain (
		.clk       (clk),
		.reset_n   (reset_n),
		.mix_active(mix_active),
		.coded     (blk_coded),
		.pixel_addr(pixel_addr),
		.preds     (preds),
		.residual  (residual),
		.out_valid (out_valid),
		.out_word  (out_word)
	);

endmodule

// ==== logic/mc_ref_splitter.sv ====
/*
 * Reference beat splitter
 * Counts beats over the 9x5 reference area and hands each lane its pair
 */
module mc_ref_splitter
	import mc_geom_pkg::*;
	import mc_stream_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   fetching,
	input  half_flags_t            flags,
	input  logic                   ref_valid,
	input  ref_beat_t              ref_beat,
	output lane_pair_t [LANES-1:0] pairs,
	output logic                   fetch_done
);

	logic [$clog2(BEATS_PER_ROW)-1:0] beat_col;	// 0..4
	logic [ROW_W-1:0]                 beat_row;	// 0..8
	logic [PIX_W-1:0]                 px1_q;	// Right pixel of the previous beat
	logic                             accept;
	logic                             row_end;
	logic                             last_beat;
	lane_pair_t [LANES-1:0]           pair_d;

	assign accept    = fetching && ref_valid && !fetch_done;
	assign row_end   = (beat_col == BEATS_PER_ROW - 1);
	assign last_beat = row_end && (beat_row == REF_ROWS - 1);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			beat_col <= '0;
			beat_row <= '0;
		end else if (accept) begin
			beat_col <= row_end ? '0 : beat_col + 1'b1;
			if (last_beat)
				beat_row <= '0;
			else if (row_end)
				beat_row <= beat_row + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			px1_q <= ref_beat.px1;
	end

	// --------------------
	// Pair selection
	always_comb begin
		// Even lane: beats 0..3, pixels 2c and 2c+1
		pair_d[0].valid = accept && !row_end;
		pair_d[0].a     = ref_beat.px0;
		pair_d[0].b     = flags.xhalf ? ref_beat.px1 : ref_beat.px0;
		pair_d[0].col   = beat_col[COL_W-1:0];
		pair_d[0].row   = beat_row;
		// Odd lane with xhalf straddles two beats, one column lower
		if (flags.xhalf) begin
			pair_d[1].valid = accept && (beat_col != 0);
			pair_d[1].a     = px1_q;
			pair_d[1].b     = ref_beat.px0;
			pair_d[1].col   = COL_W'(beat_col - 1'b1);
		end else begin
			pair_d[1].valid = accept && !row_end;
			pair_d[1].a     = ref_beat.px1;
			pair_d[1].b     = ref_beat.px1;
			pair_d[1].col   = beat_col[COL_W-1:0];
		end
		pair_d[1].row = beat_row;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pairs      <= '0;
			fetch_done <= 1'b0;
		end else begin
			pairs      <= pair_d;
			fetch_done <= accept && last_beat;	// One cycle, with the last pairs
		end
	end

	// Fetch closes right after the 45th beat, so no further beat is counted
	a_beat_bound: assert property (@(posedge clk) disable iff (!reset_n)
		fetch_done |=> !fetching);

endmodule

// ==== logic/mc_stream_pkg.sv ====
/*
 * Motion compensation stream types
 * Packed layouts for reference beats, lane pairs, residuals and output words
 */
package mc_stream_pkg;
	import mc_geom_pkg::*;

	// Two pixels per beat, left pixel in the low byte
	typedef struct packed {
		logic [PIX_W-1:0] px1;	// Right pixel
		logic [PIX_W-1:0] px0;	// Left pixel
	} ref_beat_t;

	typedef struct packed {
		logic xhalf;
		logic yhalf;
	} half_flags_t;

	// --------------------
	// One lane's horizontal pixel pair
	typedef struct packed {
		logic             valid;
		logic [PIX_W-1:0] a;
		logic [PIX_W-1:0] b;
		logic [COL_W-1:0] col;	// Output column within the lane
		logic [ROW_W-1:0] row;	// Reference row 0..8
	} lane_pair_t;

	typedef struct packed {
		logic signed [RES_W-1:0] d1;	// Odd pixel
		logic signed [RES_W-1:0] d0;	// Even pixel
	} residual_t;

	// Clipped output word, same pixel layout as a reference beat
	typedef struct packed {
		logic [PRED_ADDR_W-1:0] addr;
		ref_beat_t              data;
	} recon_word_t;

endpackage

// ==== m2v_mc.f ====
+incdir+test
logic/mc_geom_pkg.sv
logic/mc_stream_pkg.sv
logic/mc_block_ctrl.sv
logic/mc_ref_splitter.sv
logic/mc_half_pel_lane.sv
logic/mc_recon_drain.sv
logic/mc_recon_top.sv
test/mc_recon_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the mc_recon testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=mc_recon_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module mc_recon_tb -f m2v_mc.f --Mdir "$BUILD_DIR" -o "$SIM_EXE"
if [ $? -ne 0 ]; then
	echo "Verilator compile step returned an error"
	exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// ==== test/mc_recon_model.svh ====
/*
 * Reference model for the motion compensation testbench
 * Random source, value check, expected prediction and reconstruction
 */
`ifndef MC_RECON_MODEL_SVH
`define MC_RECON_MODEL_SVH

// --------------------
// Random source
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// x^16 + x^14 + x^13 + x^11 + 1
endfunction

function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_next(lfsr_q);	// One step per bit
		v      = {v[30:0], lfsr_q[0]};
	end
	return v;
endfunction

// Residual close to one of the two ends of the signed range
function automatic logic [RES_W-1:0] extreme_residual();
	logic [31:0] pick;
	pick = take_bits(4);
	if (pick[3])
		return RES_W'(-256 + int'(pick[2:0]));
	else
		return RES_W'(255 - int'(pick[2:0]));
endfunction

// --------------------
// Failure reporting
task automatic fail_run(input string why);
	$display("%s", why);
	$display("Simulation failed");
	$fatal(1);
endtask

task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	if (got !== exp)
		fail_run($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

// --------------------
// Prediction rule
function automatic int row_xsum(input int r, input int x, input logic xhalf);
	int a;
	int b;
	a = int'(ref_px[r][x]);
	b = xhalf ? int'(ref_px[r][x+1]) : a;	// Full-pel pairs a pixel with itself
	return a + b + 1;
endfunction

function automatic int predict_pixel(input int r, input int x, input half_flags_t f);
	int ys;
	if (f.yhalf)
		ys = row_xsum(r, x, f.xhalf) + row_xsum(r + 1, x, f.xhalf);
	else
		ys = 2 * row_xsum(r, x, f.xhalf);
	return ys >> 2;
endfunction

// Add and clip, residual ignored on an uncoded block
function automatic int recon_px(input int p, input logic signed [RES_W-1:0] d, input logic cd);
	int s;
	s = cd ? p + int'(d) : p;
	if (s < 0)
		return 0;
	else if (s > 255)
		return 255;
	return s;
endfunction

task automatic build_expected(input half_flags_t f, input logic cd);
	recon_word_t w;
	int          row;
	int          col;
	for (int a = 0; a < BLOCK_ROWS * COLS_PER_LANE; a++) begin
		row        = a / COLS_PER_LANE;
		col        = a % COLS_PER_LANE;
		w.addr     = PRED_ADDR_W'(a);
		w.data.px0 = PIX_W'(recon_px(predict_pixel(row, 2 * col, f), res_next[a].d0, cd));
		w.data.px1 = PIX_W'(recon_px(predict_pixel(row, 2 * col + 1, f), res_next[a].d1, cd));
		exp_q.push_back(w);
	end
endtask

`endif

// ==== test/mc_recon_tb.sv ====
/*
 * Testbench for the motion compensation core
 * Directed half-pel blocks, then random back-to-back blocks against a model
 */
module mc_recon_tb
	import mc_geom_pkg::*;
	import mc_stream_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 5;
	localparam int MAX_GAP      = 3;	// Idle cycles before a beat
	localparam int RAND_BLOCKS  = 12;
	localparam int NUM_BLOCKS   = 4 + RAND_BLOCKS;
	localparam int BLOCK_WORDS  = BLOCK_ROWS * COLS_PER_LANE;
	localparam int WATCH_CYCLES = RESET_CYCLES + 10 +
		NUM_BLOCKS * (REF_BEATS * (MAX_GAP + 1) + 40);

	logic                   clk = 1'b0;
	logic                   reset_n;
	logic                   block_start;
	half_flags_t            flags;
	logic                   coded;
	logic                   ready;
	logic                   ref_valid;
	ref_beat_t              ref_beat;
	logic [PRED_ADDR_W-1:0] pixel_addr;
	residual_t              residual;
	logic                   out_valid;
	recon_word_t            out_word;

	// Block data and expected words
	logic [15:0]      lfsr_q = 16'd85;
	logic [PIX_W-1:0] ref_px [REF_ROWS][2 * BEATS_PER_ROW];
	residual_t        res_next [BLOCK_WORDS];	// Next block, built ahead
	residual_t        res_mem [BLOCK_WORDS];	// Block being mixed
	recon_word_t      exp_q [$];

	int                     cyc = 0;
	int                     last_beat_cyc = 0;
	int                     word_idx = 0;	// Word within the block
	int                     words_seen = 0;
	logic [PRED_ADDR_W-1:0] prev_addr = '0;
	recon_word_t            exp_w;

	`include "mc_recon_model.svh"

	mc_recon_top DUT (
		.clk        (clk),
		.reset_n    (reset_n),
		.block_start(block_start),
		.flags      (flags),
		.coded      (coded),
		.ready      (ready),
		.ref_valid  (ref_valid),
		.ref_beat   (ref_beat),
		.pixel_addr (pixel_addr),
		.residual   (residual),
		.out_valid  (out_valid),
		.out_word   (out_word)
	);

	assign residual = res_mem[pixel_addr];	// Same-cycle residual lookup

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// --------------------
	// Stimulus helpers
	task automatic next_drive_slot();
		@(posedge clk);
		#1;
	endtask

	task automatic fill_ref_random();
		for (int r = 0; r < REF_ROWS; r++)
			for (int x = 0; x < 2 * BEATS_PER_ROW; x++)
				ref_px[r][x] = PIX_W'(take_bits(PIX_W));
	endtask

	task automatic fill_res_random(input logic extreme);
		for (int a = 0; a < BLOCK_WORDS; a++) begin
			res_next[a].d0 = extreme ? extreme_residual() : RES_W'(take_bits(RES_W));
			res_next[a].d1 = extreme ? extreme_residual() : RES_W'(take_bits(RES_W));
		end
	endtask

	task automatic send_block(input half_flags_t f, input logic cd, input int max_gap);
		int gap;
		while (!ready)
			next_drive_slot();
		build_expected(f, cd);
		res_mem     = res_next;	// Previous mix ended at the last edge
		block_start = 1'b1;
		flags       = f;
		coded       = cd;
		next_drive_slot();
		block_start = 1'b0;
		compare_value("ready", 32'(ready), 32'd0);
		for (int r = 0; r < REF_ROWS; r++) begin
			for (int b = 0; b < BEATS_PER_ROW; b++) begin
				gap = int'(take_bits(2)) % (max_gap + 1);
				repeat (gap)
					next_drive_slot();
				ref_valid     = 1'b1;
				ref_beat.px0  = ref_px[r][2 * b];
				ref_beat.px1  = ref_px[r][2 * b + 1];
				last_beat_cyc = cyc;
				next_drive_slot();
				ref_valid = 1'b0;
			end
		end
	endtask

	// --------------------
	// Main sequence
	initial begin
		half_flags_t f;
		logic        cd;
		reset_n     = 1'b0;
		block_start = 1'b0;
		flags       = '0;
		coded       = 1'b0;
		ref_valid   = 1'b0;
		ref_beat    = '0;
		for (int a = 0; a < BLOCK_WORDS; a++) begin
			res_mem[a]  = '0;
			res_next[a] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_n = 1'b1;
		next_drive_slot();
		compare_value("ready", 32'(ready), 32'd1);
		compare_value("out_valid", 32'(out_valid), 32'd0);

		f = '0;	// Full-pel copy, residuals ignored
		fill_ref_random();
		fill_res_random(1'b0);
		send_block(f, 1'b0, 0);
		f.xhalf = 1'b1;
		fill_ref_random();
		fill_res_random(1'b0);
		send_block(f, 1'b0, 0);
		f.xhalf = 1'b0;
		f.yhalf = 1'b1;
		fill_ref_random();
		fill_res_random(1'b0);
		send_block(f, 1'b0, 0);
		f.xhalf = 1'b1;	// Four-pixel average, clipping at both ends
		fill_ref_random();
		fill_res_random(1'b1);
		send_block(f, 1'b1, 0);

		repeat (RAND_BLOCKS) begin
			f  = half_flags_t'(2'(take_bits(2)));
			cd = 1'(take_bits(1));
			fill_ref_random();
			fill_res_random(1'b0);
			send_block(f, cd, MAX_GAP);
		end

		while (words_seen < NUM_BLOCKS * BLOCK_WORDS)
			next_drive_slot();
		if (!out_valid && ready) begin
			$display("Simulation passed");
			$finish;
		end else begin
			fail_run("extra output word or core busy at the end of the run");
		end
	end

	// --------------------
	// Output checking at the falling edge
	always @(negedge clk) begin
		if (reset_n) begin
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					fail_run("out_valid was high with no block in flight");
				end else begin
					exp_w = exp_q.pop_front();
					compare_value("out_word.addr", 32'(out_word.addr), 32'(exp_w.addr));
					compare_value("out_word.addr vs pixel_addr", 32'(out_word.addr),
						32'(prev_addr));
					compare_value("out_word.data", 32'(out_word.data), 32'(exp_w.data));
					if (word_idx == 0)	// Mix starts two cycles after the last beat
						compare_value("first out_valid cycle", 32'(cyc),
							32'(last_beat_cyc + 3));
					if (word_idx == BLOCK_WORDS - 1)
						compare_value("ready", 32'(ready), 32'd1);
					word_idx   = (word_idx + 1) % BLOCK_WORDS;
					words_seen = words_seen + 1;
				end
			end else if (word_idx != 0) begin
				fail_run("out_valid dropped before all 32 words of a block");
			end
			prev_addr = pixel_addr;
		end
	end

	// Watchdog
	initial begin
		#(WATCH_CYCLES * CLK_PERIOD);
		fail_run("timeout waiting for the core to finish all blocks");
	end

endmodule
